// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: src.f
verilog/fetch_pkg.sv
verilog/trap_target.sv
verilog/branch_predictor.sv
verilog/fetch_ctrl.sv
verilog/fetch_pipe.sv
verilog/fetch_frontend.sv
verification/tb_fetch_frontend.sv

// File: verification/tb_fetch_frontend.sv
// fetch frontend testbench
`default_nettype none

module tb_fetch_frontend;

  localparam int CYCLE_LIMIT = 4000;

  logic         clk;
  logic         reset_n;
  logic         imem_req_valid;
  logic         imem_req_ready;
  logic [31:0]  imem_req_addr;
  logic [127:0] imem_resp_data;
  logic         commit_valid;
  fetch_pkg::cause_t commit_cause;
  logic [31:0]  commit_epc;
  logic [31:0]  csr_mepc;
  logic [31:0]  csr_sepc;
  logic [31:0]  csr_mtvec;
  logic [31:0]  csr_stvec;
  logic [15:0]  csr_medeleg;
  logic         br_valid;
  logic [31:0]  br_pc;
  logic [31:0]  br_target;
  logic         br_taken;
  logic         br_mispredict;
  logic         fetch_valid;
  logic [31:0]  fetch_pc;
  logic [127:0] fetch_data;
  logic         fetch_pred_taken;
  logic [31:0]  fetch_pred_target;
  logic         fetch_ready;

  logic [31:0]  lfsr;
  logic [31:0]  exp_pc;       // pc of the next packet to be accepted
  logic [31:0]  exp_pc_next;
  logic         trained_valid;
  logic [31:0]  trained_line;
  logic [31:0]  trained_target;
  logic         first_req;
  logic         pkt_fire;
  logic         trained_hit;
  int           pkt_count;
  int           cycles;

  fetch_frontend dut0 (
    .i_clk (clk), .i_reset_n (reset_n),
    .o_imem_req_valid (imem_req_valid), .i_imem_req_ready (imem_req_ready),
    .o_imem_req_addr (imem_req_addr), .i_imem_resp_data (imem_resp_data),
    .i_commit_valid (commit_valid), .i_commit_cause (commit_cause),
    .i_commit_epc (commit_epc), .i_csr_mepc (csr_mepc), .i_csr_sepc (csr_sepc),
    .i_csr_mtvec (csr_mtvec), .i_csr_stvec (csr_stvec), .i_csr_medeleg (csr_medeleg),
    .i_br_valid (br_valid), .i_br_pc (br_pc), .i_br_target (br_target),
    .i_br_taken (br_taken), .i_br_mispredict (br_mispredict),
    .o_fetch_valid (fetch_valid), .o_fetch_pc (fetch_pc), .o_fetch_data (fetch_data),
    .o_fetch_pred_taken (fetch_pred_taken), .o_fetch_pred_target (fetch_pred_target),
    .i_fetch_ready (fetch_ready)
  );

  // ====================================================================
  // helpers
  // ====================================================================
  task automatic report_mismatch(input string name, input logic [127:0] expv,
                                 input logic [127:0] actv);
    $display("mismatch %s expected %h actual %h", name, expv, actv);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // taps 32 22 2 1
  function automatic logic random_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], random_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] random_addr();
    return {16'h0, 14'(random_bits(14)), 2'b00};
  endfunction

  // commit rule, traps go through medeleg
  function automatic logic [31:0] commit_target(input fetch_pkg::cause_t c);
    case (c)
      fetch_pkg::SILENT_FLUSH:  return commit_epc + 32'd4;
      fetch_pkg::ANOTHER_FLUSH: return commit_epc;
      fetch_pkg::MRET:          return csr_mepc;
      fetch_pkg::SRET:          return csr_sepc;
      default:                  return csr_medeleg[c[3:0]] ? csr_stvec : csr_mtvec;
    endcase
  endfunction

  function automatic fetch_pkg::cause_t pick_trap(input logic [3:0] code);
    if (code == 4'd10 || code == 4'd14) begin
      return fetch_pkg::ILLEGAL_INST;
    end
    return fetch_pkg::cause_t'({1'b0, code});
  endfunction

  task automatic commit_event(input fetch_pkg::cause_t c, input logic [31:0] epc);
    @(posedge clk);
    #1;
    commit_valid = 1'b1;
    commit_cause = c;
    commit_epc   = epc;
    @(posedge clk);
    #1;
    commit_valid = 1'b0;
  endtask

  task automatic branch_event(input logic [31:0] pc, input logic [31:0] target,
                              input logic taken);
    @(posedge clk);
    #1;
    br_valid      = 1'b1;
    br_mispredict = 1'b1;
    br_pc         = pc;
    br_target     = target;
    br_taken      = taken;
    @(posedge clk);
    #1;
    br_valid = 1'b0;
  endtask

  task automatic wait_packets(input int n);
    int start;
    start = pkt_count;
    while (pkt_count < start + n) begin
      @(posedge clk);
    end
  endtask

  // ====================================================================
  // clock, random handshakes, memory model
  // ====================================================================
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    logic        mem_fire;
    logic [31:0] mem_addr;
    mem_fire = imem_req_valid && imem_req_ready;
    mem_addr = imem_req_addr;
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      report_failure("timeout, run did not finish within the cycle limit");
    end else begin
      #1;
      if (mem_fire) begin
        imem_resp_data = {4{mem_addr}};  // data is the request address
      end
      imem_req_ready = random_bit() | random_bit();  // low a quarter of the time
      fetch_ready    = random_bit() | random_bit();
    end
  end

  // ====================================================================
  // reference of the accepted pc stream
  // ====================================================================
  assign pkt_fire    = fetch_valid && fetch_ready;
  assign trained_hit = trained_valid && ((exp_pc & ~32'hF) == trained_line);

  always_comb begin
    exp_pc_next = exp_pc;
    if (pkt_fire) begin
      exp_pc_next = trained_hit ? trained_target : (exp_pc & ~32'hF) + 32'd16;
    end
    if (commit_valid) begin
      exp_pc_next = commit_target(commit_cause);
    end else if (br_valid && br_mispredict) begin
      exp_pc_next = br_target;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      exp_pc        <= fetch_pkg::RESET_VECTOR;
      trained_valid <= 1'b0;
      first_req     <= 1'b1;
      pkt_count     <= 0;
    end else begin
      exp_pc <= exp_pc_next;
      if (imem_req_valid) begin
        first_req <= 1'b0;
      end
      if (pkt_fire) begin
        pkt_count <= pkt_count + 1;
      end
      if (br_valid && br_mispredict && br_taken) begin
        trained_valid  <= 1'b1;
        trained_line   <= br_pc & ~32'hF;
        trained_target <= br_target;
      end
    end
  end

  // ====================================================================
  // checkers
  // ====================================================================
  a_reset_quiet: assert property (@(posedge clk) $rose(reset_n) |->
    !imem_req_valid && !fetch_valid)
    else report_failure("valid output high right after reset");

  a_first_req_time: assert property (@(posedge clk) $rose(reset_n) |=> imem_req_valid)
    else report_failure("first request did not rise one cycle after reset");

  a_first_req: assert property (@(posedge clk) disable iff (!reset_n)
    imem_req_valid && first_req |-> imem_req_addr == fetch_pkg::RESET_VECTOR)
    else report_mismatch("first request", 128'(fetch_pkg::RESET_VECTOR),
                         128'($sampled(imem_req_addr)));

  a_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
    imem_req_valid && !imem_req_ready |=>
      !imem_req_valid || $stable(imem_req_addr) || commit_valid ||
      (br_valid && br_mispredict))
    else report_failure("request address changed while the request was stalled");

  a_pkt_pc: assert property (@(posedge clk) disable iff (!reset_n)
    pkt_fire |-> fetch_pc == exp_pc)
    else report_mismatch("packet pc", 128'($sampled(exp_pc)), 128'($sampled(fetch_pc)));

  a_pkt_data: assert property (@(posedge clk) disable iff (!reset_n)
    pkt_fire |-> fetch_data == {4{exp_pc}})
    else report_mismatch("packet data", {4{$sampled(exp_pc)}}, $sampled(fetch_data));

  a_pred_taken: assert property (@(posedge clk) disable iff (!reset_n)
    pkt_fire |-> fetch_pred_taken == trained_hit)
    else report_mismatch("predicted taken", 128'($sampled(trained_hit)),
                         128'($sampled(fetch_pred_taken)));

  a_pred_target: assert property (@(posedge clk) disable iff (!reset_n)
    pkt_fire && trained_hit |-> fetch_pred_target == trained_target)
    else report_mismatch("predicted target", 128'($sampled(trained_target)),
                         128'($sampled(fetch_pred_target)));

  a_pkt_hold: assert property (@(posedge clk) disable iff (!reset_n)
    fetch_valid && !fetch_ready && !commit_valid && !(br_valid && br_mispredict) |=>
      fetch_valid && $stable(fetch_pc) && $stable(fetch_data) &&
      $stable(fetch_pred_taken) && $stable(fetch_pred_target))
    else report_failure("fetch packet dropped or changed under back-pressure");

  // ====================================================================
  // test sequence
  // ====================================================================
  initial begin
    fetch_pkg::cause_t c;
    lfsr           = 32'd68657;
    cycles         = 0;
    reset_n        = 1'b0;
    imem_req_ready = 1'b0;
    imem_resp_data = '0;
    commit_valid   = 1'b0;
    commit_cause   = fetch_pkg::SILENT_FLUSH;
    commit_epc     = '0;
    csr_mepc       = '0;
    csr_sepc       = '0;
    csr_mtvec      = '0;
    csr_stvec      = '0;
    csr_medeleg    = '0;
    br_valid       = 1'b0;
    br_pc          = '0;
    br_target      = '0;
    br_taken       = 1'b0;
    br_mispredict  = 1'b0;
    fetch_ready    = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;

    wait_packets(40);  // sequential stream under random stalls

    for (int i = 0; i < 10; i++) begin  // traps with random delegation
      @(posedge clk);
      #1;
      csr_medeleg = 16'(random_bits(16));
      csr_mtvec   = random_addr();
      csr_stvec   = random_addr();
      commit_event(pick_trap(4'(random_bits(4))), random_addr());
      wait_packets(3);
    end

    for (int i = 0; i < 4; i++) begin  // flush, re-fetch, mret, sret
      @(posedge clk);
      #1;
      csr_mepc = random_addr();
      csr_sepc = random_addr();
      c = fetch_pkg::cause_t'(5'd16 + 5'(i));
      commit_event(c, random_addr());
      wait_packets(3);
    end

    for (int i = 0; i < 6; i++) begin  // not-taken mispredicts, upper BIM half
      branch_event(random_addr() | 32'h200, random_addr(), 1'b0);
      wait_packets(3);
    end

    branch_event(32'h0000_2048, 32'h0000_3000, 1'b1);
    wait_packets(4);
    commit_event(fetch_pkg::ANOTHER_FLUSH, 32'h0000_2044);
    wait_packets(4);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
// BTB and bimodal line predictor
`default_nettype none

module branch_predictor (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic [fetch_pkg::VADDR_W-1:0] i_lookup_pc,
  input  logic                          i_br_valid,
  input  logic [fetch_pkg::VADDR_W-1:0] i_br_pc,
  input  logic [fetch_pkg::VADDR_W-1:0] i_br_target,
  input  logic                          i_br_taken,
  input  logic                          i_br_mispredict,
  output logic                          o_s1_pred_taken,
  output logic [fetch_pkg::VADDR_W-1:0] o_s1_pred_target
);

  logic [fetch_pkg::BTB_TAG_W-1:0]   r_btb_tag    [fetch_pkg::BTB_ENTRIES];
  logic [fetch_pkg::VADDR_W-1:0]     r_btb_target [fetch_pkg::BTB_ENTRIES];
  logic [fetch_pkg::BTB_ENTRIES-1:0] r_btb_valid;
  logic [1:0]                        r_bim        [fetch_pkg::BIM_ENTRIES];

  logic [fetch_pkg::BTB_IDX_W-1:0] r_s1_btb_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0] r_s1_tag;
  logic [fetch_pkg::BIM_IDX_W-1:0] r_s1_bim_idx;
  logic                            w_s1_btb_hit;

  logic [fetch_pkg::BTB_IDX_W-1:0] w_upd_btb_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0] w_upd_tag;
  logic [fetch_pkg::BIM_IDX_W-1:0] w_upd_bim_idx;
  logic [1:0]                      w_upd_cnt;
  logic                            w_btb_write;

  // ======================================================================
  // lookup, answered in stage 1
  // ======================================================================
  always_ff @(posedge i_clk) begin
    r_s1_btb_idx <= i_lookup_pc[fetch_pkg::LINE_OFS_W +: fetch_pkg::BTB_IDX_W];
    r_s1_tag     <= i_lookup_pc[fetch_pkg::VADDR_W-1 -: fetch_pkg::BTB_TAG_W];
    r_s1_bim_idx <= i_lookup_pc[fetch_pkg::LINE_OFS_W +: fetch_pkg::BIM_IDX_W];
  end

  assign w_s1_btb_hit     = r_btb_valid[r_s1_btb_idx] & (r_btb_tag[r_s1_btb_idx] == r_s1_tag);
  assign o_s1_pred_taken  = w_s1_btb_hit & r_bim[r_s1_bim_idx][1];
  assign o_s1_pred_target = r_btb_target[r_s1_btb_idx];

  // ======================================================================
  // training from branch resolution
  // ======================================================================
  assign w_upd_btb_idx = i_br_pc[fetch_pkg::LINE_OFS_W +: fetch_pkg::BTB_IDX_W];
  assign w_upd_tag     = i_br_pc[fetch_pkg::VADDR_W-1 -: fetch_pkg::BTB_TAG_W];
  assign w_upd_bim_idx = i_br_pc[fetch_pkg::LINE_OFS_W +: fetch_pkg::BIM_IDX_W];
  assign w_upd_cnt     = r_bim[w_upd_bim_idx];
  assign w_btb_write   = i_br_valid & i_br_mispredict & i_br_taken;  // missed taken branch

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_btb_valid <= '0;
    end else if (w_btb_write) begin
      r_btb_valid[w_upd_btb_idx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_btb_write) begin
      r_btb_tag[w_upd_btb_idx]    <= w_upd_tag;
      r_btb_target[w_upd_btb_idx] <= i_br_target;
    end
  end

  // 2-bit saturating counters
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < fetch_pkg::BIM_ENTRIES; i++) begin
        r_bim[i] <= fetch_pkg::BIM_WEAK_NT;
      end
    end else if (i_br_valid) begin
      if (i_br_taken && (w_upd_cnt != 2'd3)) begin
        r_bim[w_upd_bim_idx] <= w_upd_cnt + 2'd1;
      end else if (!i_br_taken && (w_upd_cnt != 2'd0)) begin
        r_bim[w_upd_bim_idx] <= w_upd_cnt - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fetch_ctrl.sv
// fetch address and request control
`default_nettype none

module fetch_ctrl (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_flush,
  input  logic [fetch_pkg::VADDR_W-1:0] i_flush_target,
  input  logic                          i_br_valid,
  input  logic                          i_br_mispredict,
  input  logic [fetch_pkg::VADDR_W-1:0] i_br_target,
  input  logic                          i_s1_valid,
  input  logic [fetch_pkg::VADDR_W-1:0] i_s1_pc,
  input  logic                          i_s1_pred_taken,
  input  logic [fetch_pkg::VADDR_W-1:0] i_s1_pred_target,
  input  logic                          i_s2_stall,
  input  logic                          i_fetch_ready,
  input  logic                          i_imem_req_ready,
  output logic                          o_imem_req_valid,
  output logic [fetch_pkg::VADDR_W-1:0] o_imem_req_addr,
  output logic                          o_req_fire,
  output logic                          o_kill
);

  typedef enum logic [1:0] {
    INIT          = 2'd0,
    FETCH         = 2'd1,
    WAIT_BUF_FREE = 2'd2
  } fsm_state_t;

  fsm_state_t                    r_state;
  fsm_state_t                    w_state_next;
  logic [fetch_pkg::VADDR_W-1:0] r_fetch_addr;      // next line to request
  logic [fetch_pkg::VADDR_W-1:0] w_fetch_addr_next;
  logic                          w_redirect;
  logic [fetch_pkg::VADDR_W-1:0] w_redirect_target;
  logic                          w_pred;
  logic                          w_hold;

  // ======================================================================
  // address select
  // ======================================================================
  assign w_redirect        = i_flush | (i_br_valid & i_br_mispredict);
  assign w_redirect_target = i_flush ? i_flush_target : i_br_target;  // commit wins
  assign w_pred            = i_s1_valid & i_s1_pred_taken;
  assign w_hold            = i_s2_stall & ~w_redirect;  // buffer full, pipe not killed

  assign o_imem_req_addr = w_redirect ? w_redirect_target :
                           w_pred     ? i_s1_pred_target  :
                                        r_fetch_addr;

  // no request while stage 2 is held, unless a redirect kills it
  assign o_imem_req_valid = (r_state != INIT) &
                            (w_redirect | ((r_state == FETCH) & ~i_s2_stall));
  assign o_req_fire       = o_imem_req_valid & i_imem_req_ready;
  assign o_kill           = w_redirect;

  always_comb begin
    if (o_req_fire) begin
      w_fetch_addr_next = (o_imem_req_addr & ~fetch_pkg::LINE_MASK) + fetch_pkg::LINE_STEP;
    end else if (w_hold && i_s1_valid) begin
      w_fetch_addr_next = i_s1_pc;          // stage 1 dropped, fetch it again
    end else begin
      w_fetch_addr_next = o_imem_req_addr;  // keeps a redirect or prediction
    end
  end

  // ======================================================================
  // state machine
  // ======================================================================
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      INIT: begin
        w_state_next = FETCH;
      end
      FETCH: begin
        if (w_hold) begin
          w_state_next = WAIT_BUF_FREE;
        end
      end
      WAIT_BUF_FREE: begin
        if (w_redirect || i_fetch_ready) begin  // held packet gone
          w_state_next = FETCH;
        end
      end
      default: begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= INIT;
      r_fetch_addr <= fetch_pkg::RESET_VECTOR;
    end else begin
      r_state      <= w_state_next;
      r_fetch_addr <= w_fetch_addr_next;
    end
  end

  // a stalled request only moves for a redirect or a stage-1 prediction
  a_req_addr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_imem_req_valid && !i_imem_req_ready |=>
      $stable(o_imem_req_addr) || w_redirect || w_pred)
    else $error("request address changed while stalled");

endmodule

`default_nettype wire

// File: verilog/fetch_frontend.sv
// instruction fetch frontend top
`default_nettype none

module fetch_frontend (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  // instruction memory
  output logic                          o_imem_req_valid,
  input  logic                          i_imem_req_ready,
  output logic [fetch_pkg::VADDR_W-1:0] o_imem_req_addr,
  input  logic [fetch_pkg::LINE_W-1:0]  i_imem_resp_data,
  // commit and CSRs
  input  logic                          i_commit_valid,
  input  fetch_pkg::cause_t             i_commit_cause,
  input  logic [fetch_pkg::VADDR_W-1:0] i_commit_epc,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_mepc,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_sepc,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_mtvec,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_stvec,
  input  logic [15:0]                   i_csr_medeleg,
  // branch resolution
  input  logic                          i_br_valid,
  input  logic [fetch_pkg::VADDR_W-1:0] i_br_pc,
  input  logic [fetch_pkg::VADDR_W-1:0] i_br_target,
  input  logic                          i_br_taken,
  input  logic                          i_br_mispredict,
  // fetch buffer
  output logic                          o_fetch_valid,
  output logic [fetch_pkg::VADDR_W-1:0] o_fetch_pc,
  output logic [fetch_pkg::LINE_W-1:0]  o_fetch_data,
  output logic                          o_fetch_pred_taken,
  output logic [fetch_pkg::VADDR_W-1:0] o_fetch_pred_target,
  input  logic                          i_fetch_ready
);

  logic                          w_flush;
  logic [fetch_pkg::VADDR_W-1:0] w_flush_target;
  logic                          w_s1_valid;
  logic [fetch_pkg::VADDR_W-1:0] w_s1_pc;
  logic                          w_s1_pred_taken;
  logic [fetch_pkg::VADDR_W-1:0] w_s1_pred_target;
  logic                          w_s2_stall;
  logic                          w_req_fire;
  logic                          w_kill;

  trap_target u_trap_target (
    .i_commit_valid (i_commit_valid),
    .i_commit_cause (i_commit_cause),
    .i_commit_epc   (i_commit_epc),
    .i_csr_mepc     (i_csr_mepc),
    .i_csr_sepc     (i_csr_sepc),
    .i_csr_mtvec    (i_csr_mtvec),
    .i_csr_stvec    (i_csr_stvec),
    .i_csr_medeleg  (i_csr_medeleg),
    .o_flush        (w_flush),
    .o_flush_target (w_flush_target)
  );

  fetch_ctrl u_fetch_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_flush          (w_flush),
    .i_flush_target   (w_flush_target),
    .i_br_valid       (i_br_valid),
    .i_br_mispredict  (i_br_mispredict),
    .i_br_target      (i_br_target),
    .i_s1_valid       (w_s1_valid),
    .i_s1_pc          (w_s1_pc),
    .i_s1_pred_taken  (w_s1_pred_taken),
    .i_s1_pred_target (w_s1_pred_target),
    .i_s2_stall       (w_s2_stall),
    .i_fetch_ready    (i_fetch_ready),
    .i_imem_req_ready (i_imem_req_ready),
    .o_imem_req_valid (o_imem_req_valid),
    .o_imem_req_addr  (o_imem_req_addr),
    .o_req_fire       (w_req_fire),
    .o_kill           (w_kill)
  );

  fetch_pipe u_fetch_pipe (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_req_fire          (w_req_fire),
    .i_req_addr          (o_imem_req_addr),
    .i_kill              (w_kill),
    .i_imem_resp_data    (i_imem_resp_data),
    .i_s1_pred_taken     (w_s1_pred_taken),
    .i_s1_pred_target    (w_s1_pred_target),
    .i_fetch_ready       (i_fetch_ready),
    .o_s1_valid          (w_s1_valid),
    .o_s1_pc             (w_s1_pc),
    .o_s2_stall          (w_s2_stall),
    .o_fetch_valid       (o_fetch_valid),
    .o_fetch_pc          (o_fetch_pc),
    .o_fetch_data        (o_fetch_data),
    .o_fetch_pred_taken  (o_fetch_pred_taken),
    .o_fetch_pred_target (o_fetch_pred_target)
  );

  // looks up every request address, answers in stage 1
  branch_predictor u_branch_predictor (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_lookup_pc      (o_imem_req_addr),
    .i_br_valid       (i_br_valid),
    .i_br_pc          (i_br_pc),
    .i_br_target      (i_br_target),
    .i_br_taken       (i_br_taken),
    .i_br_mispredict  (i_br_mispredict),
    .o_s1_pred_taken  (w_s1_pred_taken),
    .o_s1_pred_target (w_s1_pred_target)
  );

endmodule

`default_nettype wire

// File: verilog/fetch_pipe.sv
// fetch stage 1 and stage 2 registers
`default_nettype none

module fetch_pipe (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_req_fire,
  input  logic [fetch_pkg::VADDR_W-1:0] i_req_addr,
  input  logic                          i_kill,
  input  logic [fetch_pkg::LINE_W-1:0]  i_imem_resp_data,
  input  logic                          i_s1_pred_taken,
  input  logic [fetch_pkg::VADDR_W-1:0] i_s1_pred_target,
  input  logic                          i_fetch_ready,
  output logic                          o_s1_valid,
  output logic [fetch_pkg::VADDR_W-1:0] o_s1_pc,
  output logic                          o_s2_stall,
  output logic                          o_fetch_valid,
  output logic [fetch_pkg::VADDR_W-1:0] o_fetch_pc,
  output logic [fetch_pkg::LINE_W-1:0]  o_fetch_data,
  output logic                          o_fetch_pred_taken,
  output logic [fetch_pkg::VADDR_W-1:0] o_fetch_pred_target
);

  logic r_s1_valid;
  logic r_s2_valid;

  assign o_s2_stall    = r_s2_valid & ~i_fetch_ready;
  assign o_s1_valid    = r_s1_valid;
  assign o_fetch_valid = r_s2_valid;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      // a kill drops the old stage 1, the new target request still enters
      r_s1_valid <= i_req_fire & (i_kill | ~o_s2_stall);
      if (i_kill) begin
        r_s2_valid <= 1'b0;
      end else if (!o_s2_stall) begin
        r_s2_valid <= r_s1_valid;
      end
    end
  end

  // payload, qualified by the valid bits
  always_ff @(posedge i_clk) begin
    if (i_req_fire) begin
      o_s1_pc <= i_req_addr;
    end
    if (!o_s2_stall) begin
      o_fetch_pc          <= o_s1_pc;
      o_fetch_data        <= i_imem_resp_data;  // memory answers during stage 1
      o_fetch_pred_taken  <= i_s1_pred_taken;
      o_fetch_pred_target <= i_s1_pred_target;
    end
  end

  // a held stage 2 takes no new request unless the pipe is killed
  a_no_fire_on_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_s2_stall && !i_kill |-> !i_req_fire)
    else $error("request accepted while stage 2 is held");

endmodule

`default_nettype wire

// File: verilog/fetch_pkg.sv
// instruction fetch frontend
// shared definitions
`default_nettype none

package fetch_pkg;

  // ======================================================================
  // address and line geometry
  // ======================================================================
  localparam int VADDR_W    = 32;
  localparam int XLEN_W     = 32;
  localparam int LINE_BYTES = 16;
  localparam int LINE_W     = LINE_BYTES * 8;        // 128
  localparam int LINE_OFS_W = $clog2(LINE_BYTES);    // 4

  localparam logic [VADDR_W-1:0] LINE_MASK    = VADDR_W'(LINE_BYTES - 1);
  localparam logic [VADDR_W-1:0] LINE_STEP    = VADDR_W'(LINE_BYTES);
  localparam logic [VADDR_W-1:0] INST_STEP    = VADDR_W'(4);
  localparam logic [VADDR_W-1:0] RESET_VECTOR = 32'h0000_1000;

  // ======================================================================
  // predictor sizes
  // ======================================================================
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W   = VADDR_W - LINE_OFS_W - BTB_IDX_W;
  localparam int BIM_ENTRIES = 64;
  localparam int BIM_IDX_W   = $clog2(BIM_ENTRIES);

  localparam logic [1:0] BIM_WEAK_NT = 2'd1;  // 2 and up predicts taken

  // commit event, 0..15 follow the mcause exception codes
  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN  = 5'd0,
    INST_ACC_FAULT      = 5'd1,
    ILLEGAL_INST        = 5'd2,
    BREAKPOINT          = 5'd3,
    LOAD_ADDR_MISALIGN  = 5'd4,
    LOAD_ACC_FAULT      = 5'd5,
    STAMO_ADDR_MISALIGN = 5'd6,
    STAMO_ACC_FAULT     = 5'd7,
    ECALL_U             = 5'd8,
    ECALL_S             = 5'd9,
    ECALL_M             = 5'd11,
    INST_PAGE_FAULT     = 5'd12,
    LOAD_PAGE_FAULT     = 5'd13,
    STAMO_PAGE_FAULT    = 5'd15,
    SILENT_FLUSH        = 5'd16,
    ANOTHER_FLUSH       = 5'd17,
    MRET                = 5'd18,
    SRET                = 5'd19
  } cause_t;

endpackage

`default_nettype wire

// File: verilog/trap_target.sv
// commit redirect target
`default_nettype none

module trap_target (
  input  logic                          i_commit_valid,
  input  fetch_pkg::cause_t             i_commit_cause,
  input  logic [fetch_pkg::VADDR_W-1:0] i_commit_epc,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_mepc,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_sepc,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_mtvec,
  input  logic [fetch_pkg::XLEN_W-1:0]  i_csr_stvec,
  input  logic [15:0]                   i_csr_medeleg,
  output logic                          o_flush,
  output logic [fetch_pkg::VADDR_W-1:0] o_flush_target
);

  logic w_delegated;  // trap goes to S mode
  logic w_cause_known;

  assign o_flush = i_commit_valid;

  // each trap looks at its own medeleg bit
  assign w_delegated = i_csr_medeleg[i_commit_cause[3:0]];

  always_comb begin
    case (i_commit_cause)
      fetch_pkg::SILENT_FLUSH:
        o_flush_target = i_commit_epc + fetch_pkg::INST_STEP;  // skip the instruction
      fetch_pkg::ANOTHER_FLUSH:
        o_flush_target = i_commit_epc;                         // re-execute it
      fetch_pkg::MRET:
        o_flush_target = i_csr_mepc[fetch_pkg::VADDR_W-1:0];
      fetch_pkg::SRET:
        o_flush_target = i_csr_sepc[fetch_pkg::VADDR_W-1:0];
      default: begin
        if (w_delegated) begin
          o_flush_target = i_csr_stvec[fetch_pkg::VADDR_W-1:0];
        end else begin
          o_flush_target = i_csr_mtvec[fetch_pkg::VADDR_W-1:0];
        end
      end
    endcase
  end

  // 10 and 14 are reserved codes, anything above SRET is unused
  assign w_cause_known = (i_commit_cause <= fetch_pkg::SRET) &&
                         (i_commit_cause != 5'd10) &&
                         (i_commit_cause != 5'd14);

  always_comb begin
    a_cause_known: assert (!i_commit_valid || w_cause_known)
      else $error("commit with undefined cause %0d", i_commit_cause);
  end

endmodule

`default_nettype wire
